//--- flist.f
verilog/rtg_pkg.sv
verilog/rtg_fetch.sv
verilog/rtg_timing.sv
verilog/rtg_pixel.sv
verilog/rtg_video_top.sv
bench/rtg_checker.sv
bench/rtg_tb.sv

//--- run.sh
#!/bin/sh
# build and run the RTG video testbench
rm -f sim.log
verilator --binary --timing --assert --top-module rtg_tb -Mdir obj_dir -o rtg_sim \
  -f flist.f > sim.log 2>&1 &&
  ./obj_dir/rtg_sim >> sim.log 2>&1 ||
  echo "build or simulation step returned an error" >> sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" || {
  echo "simulation failed, see sim.log"
  exit 1
}

//--- bench/rtg_tb.sv
`timescale 1ns/1ns

module rtg_tb import rtg_pkg::*; ();

  localparam int    LINE_CYC    = 100;        // clocks per line
  localparam int    HBLANK_END  = 88;         // active from here
  localparam int    FRAME_LINES = 12;
  localparam int    VBL_LINES   = 4;
  localparam int    RESET_CYC   = 8;
  localparam int    N_FRAMES    = 7;
  localparam longint TIMEOUT_NS =
    longint'(RESET_CYC + 260 + N_FRAMES * LINE_CYC * FRAME_LINES) * 100 + 100000;
  localparam logic [20:0] BASE  = 21'h0a1234; // bits 23 and 21 set

  logic        clk_114;
  logic        arst_n;
  rtg_cfg_t    cfg;
  video_pix_t  chip_pix;
  video_sync_t chip_sync;
  logic        osd_window;
  logic        osd_pixel;
  clut_wr_t    clut_wr;
  wb_m2s_t     wb_o;
  wb_s2m_t     wb_i     = '0;
  video_pix_t  vid_pix;
  video_sync_t vid_sync;
  integer      seed     = 32'h48b3_3ec5;
  int          wait_cnt = 0;                  // slave wait states left
  int          mism_cnt;
  int          other_cnt;

  rtg_video_top #(.FIFO_DEPTH(16)) dut_i (
    .clk_114(clk_114), .arst_n(arst_n), .cfg(cfg), .chip_pix(chip_pix),
    .chip_sync(chip_sync), .osd_window(osd_window), .osd_pixel(osd_pixel),
    .clut_wr(clut_wr), .wb_o(wb_o), .wb_i(wb_i), .vid_pix(vid_pix), .vid_sync(vid_sync)
  );

  rtg_checker chk_i (
    .clk_114(clk_114), .arst_n(arst_n), .cfg(cfg), .chip_pix(chip_pix),
    .chip_sync(chip_sync), .osd_window(osd_window), .osd_pixel(osd_pixel),
    .wb_o(wb_o), .wb_i(wb_i), .vid_pix(vid_pix), .vid_sync(vid_sync),
    .mism_cnt(mism_cnt), .other_cnt(other_cnt)
  );

  always #50 clk_114 = ~clk_114;              // 100 ns period

  function automatic logic [15:0] mem_word(input logic [23:0] a);
    return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
  endfunction

  function automatic video_pix_t clut_colour(input logic [7:0] i);
    return '{r: i ^ 8'h3c, g: ~i, b: {i[3:0], i[7:4]}};
  endfunction

  function automatic rtg_cfg_t make_cfg(input logic ena, input logic clut,
                                        input logic [3:0] pw, input logic [6:0] vbend);
    return '{ena: ena, clut: clut, pixel_width: pw, vbend: vbend, base: BASE};
  endfunction

  //////////////////////////////
  // frame buffer slave, random wait
  always @(posedge clk_114) begin
    if (wb_i.ack) begin
      wb_i.ack <= 1'b0;
      wait_cnt <= $random(seed) & 3;
    end else if (wb_o.cyc && wb_o.stb) begin
      if (wait_cnt == 0) begin
        wb_i.dat <= mem_word(wb_o.adr);
        wb_i.ack <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  task automatic load_clut();
    for (int i = 0; i < 256; i++) begin
      @(posedge clk_114);
      clut_wr <= '{en: 1'b1, idx: 8'(i), col: clut_colour(8'(i))};
    end
    @(posedge clk_114);
    clut_wr <= '0;
  endtask

  // one chipset frame, cfg switched on its first vblank clock
  task automatic run_frame(input rtg_cfg_t c);
    logic hs;
    logic vs;
    for (int ln = 0; ln < FRAME_LINES; ln++) begin
      for (int cc = 0; cc < LINE_CYC; cc++) begin
        @(posedge clk_114);
        if (ln == 0 && cc == 0) cfg <= c;
        hs = !(cc >= 10 && cc < 20);          // sync pulse in hblank
        vs = !(ln < 2);
        chip_sync  <= '{hsync: hs, vsync: vs, csync: hs & vs,
                        hblank: (cc < HBLANK_END), vblank: (ln < VBL_LINES)};
        chip_pix   <= '{r: 8'(cc * 5), g: 8'(ln * 37 + cc), b: 8'(cc ^ (ln << 4))};
        osd_window <= ((cc >= 90 && cc < 96) || (cc >= 30 && cc < 36)) && ln[0];
        osd_pixel  <= cc[0];
      end
    end
  endtask

  //////////////////////////////
  // sequence
  initial begin
    clk_114    = 1'b0;
    arst_n     = 1'b0;
    cfg        = '0;
    chip_pix   = '0;
    chip_sync  = '{hsync: 1'b1, vsync: 1'b0, csync: 1'b0, hblank: 1'b1, vblank: 1'b1};
    osd_window = 1'b0;
    osd_pixel  = 1'b0;
    clut_wr    = '0;
    repeat (RESET_CYC) @(posedge clk_114);
    arst_n <= 1'b1;
    load_clut();
    run_frame(make_cfg(1'b0, 1'b0, 4'd0, 7'd0)); // chipset only
    run_frame(make_cfg(1'b1, 1'b0, 4'd0, 7'd2)); // rgb555, word per clock
    run_frame(make_cfg(1'b1, 1'b0, 4'd0, 7'd2));
    run_frame(make_cfg(1'b1, 1'b0, 4'd3, 7'd1));
    run_frame(make_cfg(1'b1, 1'b1, 4'd3, 7'd3)); // indexed
    run_frame(make_cfg(1'b1, 1'b1, 4'd5, 7'd0));
    run_frame(make_cfg(1'b0, 1'b0, 4'd0, 7'd0));
    repeat (4) @(posedge clk_114);
    $display("errors: %0d mismatches, %0d other", mism_cnt, other_cnt);
    if (mism_cnt == 0 && other_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the frame sequence ended");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- bench/rtg_checker.sv
`timescale 1ns/1ns

module rtg_checker import rtg_pkg::*; (
  input  logic        clk_114,
  input  logic        arst_n,
  input  rtg_cfg_t    cfg,
  input  video_pix_t  chip_pix,
  input  video_sync_t chip_sync,
  input  logic        osd_window,
  input  logic        osd_pixel,
  input  wb_m2s_t     wb_o,
  input  wb_s2m_t     wb_i,
  input  video_pix_t  vid_pix,
  input  video_sync_t vid_sync,
  output int          mism_cnt,               // wrong values seen
  output int          other_cnt               // protocol faults
);

  localparam video_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, csync: 1'b1,
                                        hblank: 1'b0, vblank: 1'b0};

  logic        hs_q;                          // model of the timing block
  logic        vb_flag;
  logic [6:0]  vb_cnt;
  logic [3:0]  pix_cnt;
  logic        clut_sel;
  rtg_word_u   word_q;                        // word on screen
  logic [23:0] word_cnt;                      // words popped this frame
  logic [23:0] ack_cnt;                       // reads done this frame
  logic        stale;                         // read in flight across a flush
  logic        cyc_q;
  logic        ack_q;
  logic        ena_q;
  video_pix_t  exp_pix;                       // due at the next edge
  video_sync_t exp_sync;
  int          rst_edges;

  //////////////////////////////
  // reference functions
  function automatic logic [23:0] mangle(input logic [23:0] w);
    logic [23:0] m;
    m     = w;
    m[22] = w[22] ^ (w[21] | w[20]);          // byte bit 23 vs 22, 21
    return m;
  endfunction

  function automatic logic [15:0] mem_word(input logic [23:0] a);
    return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
  endfunction

  function automatic video_pix_t clut_colour(input logic [7:0] i);
    return '{r: i ^ 8'h3c, g: ~i, b: {i[3:0], i[7:4]}};
  endfunction

  function automatic video_pix_t expand555(input rtg_word_u w);
    return '{r: {w.rgb.r, w.rgb.r[4:2]}, g: {w.rgb.g, w.rgb.g[4:2]},
             b: {w.rgb.b, w.rgb.b[4:2]}};
  endfunction

  function automatic video_pix_t overlay(input video_pix_t p, input logic win,
                                         input logic fg);
    video_pix_t o;
    o = p;
    if (win) begin
      o.r[7:6] = fg ? 2'b11 : 2'b00;
      o.g[7:6] = fg ? 2'b11 : 2'b00;
      o.b[7:6] = fg ? 2'b11 : 2'b10;          // blue backdrop
    end
    return o;
  endfunction

  task automatic report_mismatch(input string name, input logic [23:0] exp_v,
                                 input logic [23:0] act_v);
    $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
    mism_cnt++;
  endtask

  task automatic report_fault(input string what);
    $display("ERROR t=%0t %s", $time, what);
    other_cnt++;
  endtask

  //////////////////////////////
  // cycle model and compare
  always @(posedge clk_114) begin
    logic        blank;
    logic        strobe;
    logic        flush;
    logic [23:0] base_w;
    video_pix_t  src;
    blank  = chip_sync.hblank | vb_flag;
    strobe = cfg.ena & ~blank & (pix_cnt == cfg.pixel_width);
    flush  = chip_sync.vblank | ~cfg.ena;
    base_w = {cfg.base, 3'b000};
    if (!arst_n) begin
      if (rst_edges > 0) begin                // regs settled after first edge
        if (wb_o.cyc || wb_o.stb) report_mismatch("wb_o.cyc", 24'd0, 24'd1);
        if (vid_pix != '0) report_mismatch("vid_pix", 24'd0, vid_pix);
        if (vid_sync != SYNC_IDLE) report_mismatch("vid_sync", 24'(SYNC_IDLE), 24'(vid_sync));
      end
      rst_edges++;
      hs_q     = 1'b1;
      vb_flag  = 1'b1;
      vb_cnt   = '0;
      pix_cnt  = '0;
      clut_sel = 1'b0;
      word_q   = '0;
      word_cnt = '0;
      ack_cnt  = '0;
      stale    = 1'b0;
      cyc_q    = 1'b0;
      ack_q    = 1'b0;
      ena_q    = 1'b0;
      exp_pix  = '0;                          // first cycle out of reset
      exp_sync = SYNC_IDLE;
    end else begin
      if (vid_pix != exp_pix) report_mismatch("vid_pix", exp_pix, vid_pix);
      if (vid_sync != exp_sync) report_mismatch("vid_sync", 24'(exp_sync), 24'(vid_sync));
      if (cfg.ena && !blank) begin
        src = cfg.clut ? clut_colour(clut_sel ? word_q.idx.lo : word_q.idx.hi)
                       : expand555(word_q);
      end else begin
        src = chip_pix;                       // chipset passthrough
      end
      exp_pix  = overlay(src, osd_window, osd_pixel);
      exp_sync = chip_sync;
      // bus rules
      if (wb_o.cyc && (!cyc_q || ack_q) && !ena_q) report_fault("read started with RTG off");
      if (cyc_q && !ack_q && !wb_o.cyc) report_fault("bus cycle dropped before ack");
      if (wb_o.cyc && (wb_o.we || !wb_o.stb || wb_o.sel != 2'b11)) begin
        report_fault("bus request is not a full-word read");
      end
      if (wb_o.cyc && wb_i.ack) begin
        if (!stale && !flush) begin
          if (wb_o.adr != mangle(base_w + ack_cnt)) begin
            report_mismatch("wb_o.adr", mangle(base_w + ack_cnt), wb_o.adr);
          end
          ack_cnt++;
        end
        stale = 1'b0;
      end else if (wb_o.cyc && flush) begin
        stale = 1'b1;                         // result of the old frame
      end
      if (flush) ack_cnt = '0;
      // pixel stream
      if (strobe) begin
        word_q = mem_word(mangle(base_w + word_cnt));
        word_cnt++;
      end
      if (flush) word_cnt = '0;
      // vblank extension counted in hsync rises
      if (chip_sync.vblank) begin
        vb_flag = 1'b1;
        vb_cnt  = '0;
      end else if (vb_cnt == cfg.vbend) begin
        vb_flag = 1'b0;
      end else if (chip_sync.hsync && !hs_q) begin
        vb_cnt++;
      end
      hs_q = chip_sync.hsync;
      if (blank || strobe) begin
        pix_cnt  = '0;
        clut_sel = 1'b0;
      end else begin
        if (pix_cnt == {1'b0, cfg.pixel_width[3:1]}) clut_sel = 1'b1;
        pix_cnt++;
      end
      cyc_q = wb_o.cyc;
      ack_q = wb_i.ack;
      ena_q = cfg.ena;
    end
  end

endmodule

//--- verilog/rtg_video_top.sv
`timescale 1ns/1ns

module rtg_video_top import rtg_pkg::*; #(
  parameter int FIFO_DEPTH = 16               // fetch buffer words
) (
  input  logic        clk_114,
  input  logic        arst_n,
  input  rtg_cfg_t    cfg,                    // stable while ena set
  input  video_pix_t  chip_pix,               // chipset colour
  input  video_sync_t chip_sync,              // chipset timing
  input  logic        osd_window,
  input  logic        osd_pixel,
  input  clut_wr_t    clut_wr,                // table load port
  output wb_m2s_t     wb_o,                   // frame buffer reads
  input  wb_s2m_t     wb_i,
  output video_pix_t  vid_pix,
  output video_sync_t vid_sync
);

  logic      rtg_blank;                       // hblank or extended vblank
  logic      pix_strobe;                      // next word
  logic      clut_sel;                        // second index of word
  rtg_word_u fifo_word;

  //////////////////////////////
  // stream
  rtg_fetch #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fetch_i (
    .clk_114    (clk_114),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .vblank     (chip_sync.vblank),           // flush per frame
    .pix_strobe (pix_strobe),
    .wb_o       (wb_o),
    .wb_i       (wb_i),
    .word       (fifo_word)
  );

  //////////////////////////////
  // timing
  rtg_timing timing_i (
    .clk_114    (clk_114),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .sync       (chip_sync),
    .rtg_blank  (rtg_blank),
    .pix_strobe (pix_strobe),
    .clut_sel   (clut_sel)
  );

  //////////////////////////////
  // pixel and mixer
  rtg_pixel pixel_i (
    .clk_114    (clk_114),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .word       (fifo_word),
    .pix_strobe (pix_strobe),
    .rtg_blank  (rtg_blank),
    .clut_sel   (clut_sel),
    .chip_pix   (chip_pix),
    .chip_sync  (chip_sync),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .clut_wr    (clut_wr),
    .vid_pix    (vid_pix),
    .vid_sync   (vid_sync)
  );

endmodule

//--- verilog/rtg_pixel.sv
`timescale 1ns/1ns

module rtg_pixel import rtg_pkg::*; (
  input  logic        clk_114,
  input  logic        arst_n,
  input  rtg_cfg_t    cfg,
  input  rtg_word_u   word,                   // fifo head
  input  logic        pix_strobe,
  input  logic        rtg_blank,
  input  logic        clut_sel,
  input  video_pix_t  chip_pix,
  input  video_sync_t chip_sync,
  input  logic        osd_window,             // osd box active
  input  logic        osd_pixel,              // osd foreground
  input  clut_wr_t    clut_wr,
  output video_pix_t  vid_pix,
  output video_sync_t vid_sync
);

  rtg_word_u  word_q;                         // word on screen
  video_pix_t clut_mem [256];                 // colour table
  video_pix_t rgb_pix;
  video_pix_t clut_pix;
  video_pix_t mix_pix;
  video_pix_t osd_pix;
  logic [7:0] clut_idx;
  logic       rtg_on;

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      word_q <= '0;
    end else if (pix_strobe) begin
      word_q <= word;                         // pop lands here
    end
  end

  //////////////////////////////
  // decode
  // rgb555, top bits repeated into the low end
  assign rgb_pix.r = {word_q.rgb.r, word_q.rgb.r[4:2]};
  assign rgb_pix.g = {word_q.rgb.g, word_q.rgb.g[4:2]};
  assign rgb_pix.b = {word_q.rgb.b, word_q.rgb.b[4:2]};

  assign clut_idx = clut_sel ? word_q.idx.lo : word_q.idx.hi;

  always_ff @(posedge clk_114) begin
    if (clut_wr.en) clut_mem[clut_wr.idx] <= clut_wr.col;
  end

  assign clut_pix = clut_mem[clut_idx];       // async read

  //////////////////////////////
  // mix and overlay
  assign rtg_on  = cfg.ena & ~rtg_blank;
  assign mix_pix = !rtg_on  ? chip_pix :
                   cfg.clut ? clut_pix : rgb_pix;

  always_comb begin
    osd_pix = mix_pix;
    if (osd_window) begin
      osd_pix.r[7:6] = osd_pixel ? 2'b11 : 2'b00;
      osd_pix.g[7:6] = osd_pixel ? 2'b11 : 2'b00;
      osd_pix.b[7:6] = osd_pixel ? 2'b11 : 2'b10; // blue tint behind text
    end
  end

  // output stage, one clock after the inputs
  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      vid_pix  <= '0;
      vid_sync <= '{hsync: 1'b1, vsync: 1'b1, csync: 1'b1,
                    hblank: 1'b0, vblank: 1'b0};  // syncs idle
    end else begin
      vid_pix  <= osd_pix;
      vid_sync <= chip_sync;
    end
  end

endmodule

//--- verilog/rtg_timing.sv
`timescale 1ns/1ns

module rtg_timing import rtg_pkg::*; (
  input  logic        clk_114,
  input  logic        arst_n,
  input  rtg_cfg_t    cfg,
  input  video_sync_t sync,                   // chipset timing
  output logic        rtg_blank,
  output logic        pix_strobe,             // fetch next word
  output logic        clut_sel                // low index half
);

  logic       hs_q;                           // hsync delayed
  logic       hs_rise;
  logic       vb_flag;                        // extended vertical blank
  logic [6:0] vb_cnt;                         // lines since vblank fell
  logic [3:0] pix_cnt;                        // clocks into current word

  assign hs_rise = sync.hsync & ~hs_q;        // end of sync pulse

  //////////////////////////////
  // vertical blank extension
  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      hs_q    <= 1'b1;                        // inactive
      vb_flag <= 1'b1;                        // blank until counted in
      vb_cnt  <= '0;
    end else begin
      hs_q <= sync.hsync;
      if (sync.vblank) begin
        vb_flag <= 1'b1;
        vb_cnt  <= '0;
      end else if (vb_cnt == cfg.vbend) begin
        vb_flag <= 1'b0;                      // active area starts
      end else if (hs_rise) begin
        vb_cnt <= vb_cnt + 1'b1;
      end
    end
  end

  assign rtg_blank = sync.hblank | vb_flag;

  // strobe every pixel_width+1 clocks inside the line
  assign pix_strobe = cfg.ena & ~rtg_blank & (pix_cnt == cfg.pixel_width);

  //////////////////////////////
  // pixel pacing
  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt  <= '0;
      clut_sel <= 1'b0;
    end else if (rtg_blank || pix_strobe) begin
      pix_cnt  <= '0;                         // restart per word
      clut_sel <= 1'b0;                       // back to high index
    end else begin
      pix_cnt <= pix_cnt + 1'b1;
      if (pix_cnt == {1'b0, cfg.pixel_width[3:1]}) begin
        clut_sel <= 1'b1;                     // halfway through the word
      end
    end
  end

  //////////////////////////////
  // checks
  // vb_flag lags the chipset vblank by one clock
  a_no_strobe_in_vblank : assert property (
    @(posedge clk_114) disable iff (!arst_n)
    pix_strobe |-> !sync.vblank
  ) else $error("rtg_timing: strobe during vertical blank");

endmodule

//--- verilog/rtg_fetch.sv
`timescale 1ns/1ns

module rtg_fetch import rtg_pkg::*; #(
  parameter int FIFO_DEPTH = 16               // power of two
) (
  input  logic      clk_114,
  input  logic      arst_n,
  input  rtg_cfg_t  cfg,
  input  logic      vblank,                   // chipset frame start
  input  logic      pix_strobe,               // pop request
  output wb_m2s_t   wb_o,
  input  wb_s2m_t   wb_i,
  output rtg_word_u word                      // fifo head
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] DEPTH = (PTR_W+1)'(FIFO_DEPTH);

  rtg_word_u         mem [FIFO_DEPTH];        // pixel word storage
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    cnt_q;                   // words held
  logic [PTR_W:0]    cnt_nxt;
  logic [ADDR_W-1:1] adr_q;                   // linear word address
  logic [ADDR_W-1:1] adr_base;
  logic [ADDR_W-1:1] adr_mangled;
  logic              req_q;                   // read outstanding
  logic              drop_q;                  // result belongs to old frame
  logic              flush;
  logic              ack;
  logic              push;
  logic              pop;

  assign flush    = vblank | ~cfg.ena;        // restart every frame
  assign ack      = req_q & wb_i.ack;
  assign push     = ack & ~drop_q & ~flush;
  assign pop      = pix_strobe & (cnt_q != '0) & ~flush;
  assign cnt_nxt  = flush ? '0 :
                    cnt_q + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
  assign adr_base = {cfg.base, 3'b000};       // 16-byte base in words

  // cpu address mangling folds bit 23 with 22 and 21
  assign adr_mangled = {adr_q[24], adr_q[23] ^ (adr_q[22] | adr_q[21]), adr_q[22:1]};

  always_comb begin
    wb_o     = '0;
    wb_o.cyc = req_q;
    wb_o.stb = req_q;
    wb_o.we  = 1'b0;                          // reads only
    wb_o.adr = adr_mangled;
    wb_o.sel = 2'b11;                         // full word
  end

  //////////////////////////////
  // request and fifo control
  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      req_q  <= 1'b0;
      drop_q <= 1'b0;
      cnt_q  <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      adr_q  <= '0;
    end else begin
      cnt_q <= cnt_nxt;
      if (flush) begin
        wr_ptr <= '0;                         // empty the fifo
        rd_ptr <= '0;
      end else begin
        if (push) wr_ptr <= wr_ptr + 1'b1;
        if (pop) rd_ptr <= rd_ptr + 1'b1;
      end
      if (req_q && !wb_i.ack) begin
        drop_q <= drop_q | flush;             // wait state holds the address
      end else begin
        req_q  <= ~flush & (cnt_nxt < DEPTH); // room for one more result
        drop_q <= 1'b0;
        if (flush || drop_q) begin
          adr_q <= adr_base;                  // back to frame start
        end else if (ack) begin
          adr_q <= adr_q + 1'b1;              // next word
        end
      end
    end
  end

  // word storage
  always_ff @(posedge clk_114) begin
    if (push) mem[wr_ptr] <= wb_i.dat;
  end

  assign word = mem[rd_ptr];                  // head word taken on strobe

  //////////////////////////////
  // checks
  a_strobe_not_empty : assert property (
    @(posedge clk_114) disable iff (!arst_n)
    pix_strobe |-> cnt_q != '0
  ) else $error("rtg_fetch: pixel strobe met an empty fifo");

  a_cyc_until_ack : assert property (
    @(posedge clk_114) disable iff (!arst_n)
    wb_o.cyc && !wb_i.ack |=> wb_o.cyc && $stable(wb_o.adr)
  ) else $error("rtg_fetch: request dropped or moved before ack");

endmodule

//--- verilog/rtg_pkg.sv
package rtg_pkg;

  //////////////////////////////
  // bus widths
  localparam int ADDR_W = 25;                 // frame buffer byte address

  //////////////////////////////
  // wishbone classic
  typedef struct packed {
    logic              cyc;                   // bus cycle
    logic              stb;                   // strobe, raised with cyc
    logic              we;                    // always read here
    logic [ADDR_W-1:1] adr;                   // word address
    logic [1:0]        sel;                   // byte lanes
  } wb_m2s_t;

  typedef struct packed {
    logic [15:0] dat;                         // read data
    logic        ack;                         // transfer done
  } wb_s2m_t;

  //////////////////////////////
  // video
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } video_pix_t;

  typedef struct packed {
    logic hsync;                              // active low
    logic vsync;                              // active low
    logic csync;                              // active low
    logic hblank;                             // active high
    logic vblank;                             // active high
  } video_sync_t;

  typedef struct packed {
    logic              ena;                   // rtg screen on
    logic              clut;                  // 8-bit indexed mode
    logic [3:0]        pixel_width;           // clocks per fetch - 1
    logic [6:0]        vbend;                 // extra blank lines
    logic [ADDR_W-1:4] base;                  // frame base, 16-byte aligned
  } rtg_cfg_t;

  // one frame buffer word, hicolour or two clut indices
  typedef union packed {
    struct packed {
      logic       unused;
      logic [4:0] r;
      logic [4:0] g;
      logic [4:0] b;
    } rgb;
    struct packed {
      logic [7:0] hi;                         // shown first
      logic [7:0] lo;
    } idx;
  } rtg_word_u;

  typedef struct packed {
    logic       en;
    logic [7:0] idx;                          // table entry
    video_pix_t col;
  } clut_wr_t;

endpackage
